// File: Bender.yml
package:
  name: hist_builder

export_include_dirs:
  - include

sources:
  - src/hist_pkg.sv
  - src/hist_ctrl_fsm.sv
  - src/hist_counters.sv
  - src/hist_bank.sv
  - src/hist_builder_top.sv
  - target: test
    files:
      - tests/tb_hist_builder.sv

// File: compile.f
+incdir+include
src/hist_pkg.sv
src/hist_ctrl_fsm.sv
src/hist_counters.sv
src/hist_bank.sv
src/hist_builder_top.sv
tests/tb_hist_builder.sv

// File: include/hist_macros.svh
`ifndef HIST_MACROS_SVH
`define HIST_MACROS_SVH

// tdc bin code, 16 bins
`define HB_BIN_W 4

// bin count, saturates at all ones
`define HB_COUNT_W 6

// pixel index, 4 pixels in the block
`define HB_PIXEL_W 2

// memory address is {pixel, bin}
`define HB_ADDR_W (`HB_PIXEL_W + `HB_BIN_W)

// readout word incl. padding
`define HB_WORD_W 16

`define HB_SAMPLES 4 // per pixel and acquisition
`define HB_ACQS 40   // per frame

`endif

// File: src/hist_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module hist_bank
    import hist_pkg::*;
(
    input  logic      clk,
    input  logic      res,
    input  logic      acc_valid,
    input  bin_t      acc_bin,
    input  pixel_t    pixel,
    input  logic      clear_en,
    input  logic      read_en,
    input  addr_t     sweep_addr,
    output logic      bin_valid,
    output bin_word_t bin_word
);

    localparam int DEPTH = 1 << `HB_ADDR_W;

    count_t mem [DEPTH];

    sample_t s1;     // sample waiting for its write back
    count_t rd_q;    // count read for s1
    addr_t acc_addr;
    addr_t s1_addr;
    addr_t rd_addr;
    count_t rd_data;
    count_t s1_inc;
    logic fwd_hit;

    assign acc_addr = {pixel, acc_bin};
    assign s1_addr = {s1.pixel, s1.bin};

    // one read port, readout and accumulate never overlap
    assign rd_addr = read_en ? sweep_addr : acc_addr;
    assign rd_data = mem[rd_addr];

    // saturating increment
    assign s1_inc = (&rd_q) ? rd_q : count_t'(rd_q + 1'b1);

    // s1 writes the same bin on this edge, take its new count
    assign fwd_hit = s1.valid && (s1_addr == acc_addr);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1 <= '0;
            bin_valid <= 1'b0;
        end else begin
            s1.valid <= acc_valid;
            s1.pixel <= pixel;
            s1.bin <= acc_bin;
            bin_valid <= read_en;
        end
    end

    // stage one, read
    always_ff @(posedge clk) begin
        if (acc_valid) begin
            if (fwd_hit) begin
                rd_q <= s1_inc;
            end else begin
                rd_q <= rd_data;
            end
        end
    end

    // stage two, write back; clear shares the write port
    always_ff @(posedge clk) begin
        if (clear_en) begin
            mem[sweep_addr] <= '0;
        end else if (s1.valid) begin
            mem[s1_addr] <= s1_inc;
        end
    end

    // tagged readout word
    always_ff @(posedge clk) begin
        if (read_en) begin
            bin_word.rsvd <= '0;
            bin_word.pixel <= sweep_addr[`HB_ADDR_W-1:`HB_BIN_W];
            bin_word.bin <= sweep_addr[`HB_BIN_W-1:0];
            bin_word.count <= rd_data;
        end
    end

endmodule

`default_nettype wire

// File: src/hist_builder_top.sv
`timescale 1ns/1ps
`default_nettype none

module hist_builder_top
    import hist_pkg::*;
(
    input  logic      clk,
    input  logic      res,
    input  logic      sample_valid, // one-cycle strobe
    input  bin_t      sample_bin,
    output logic      busy,         // samples dropped while high
    output logic      bin_valid,
    output logic      frame_done,
    output bin_word_t bin_word
);

    logic sample_accept;
    logic frame_full;
    logic sweep_en;
    logic sweep_clr;
    logic sweep_last;
    logic clear_en;
    logic read_en;
    pixel_t pixel;
    addr_t sweep_addr;

    assign sample_accept = sample_valid & ~busy;

    hist_ctrl_fsm u_hist_ctrl_fsm (
        .clk        (clk),
        .res        (res),
        .frame_full (frame_full),
        .sweep_last (sweep_last),
        .busy       (busy),
        .sweep_en   (sweep_en),
        .sweep_clr  (sweep_clr),
        .clear_en   (clear_en),
        .read_en    (read_en),
        .frame_done (frame_done)
    );

    hist_counters u_hist_counters (
        .clk           (clk),
        .res           (res),
        .sample_accept (sample_accept),
        .sweep_en      (sweep_en),
        .sweep_clr     (sweep_clr),
        .pixel         (pixel),
        .frame_full    (frame_full),
        .sweep_last    (sweep_last),
        .sweep_addr    (sweep_addr)
    );

    hist_bank u_hist_bank (
        .clk        (clk),
        .res        (res),
        .acc_valid  (sample_accept),
        .acc_bin    (sample_bin),
        .pixel      (pixel),
        .clear_en   (clear_en),
        .read_en    (read_en),
        .sweep_addr (sweep_addr),
        .bin_valid  (bin_valid),
        .bin_word   (bin_word)
    );

endmodule

`default_nettype wire

// File: src/hist_counters.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module hist_counters
    import hist_pkg::*;
(
    input  logic   clk,
    input  logic   res,
    input  logic   sample_accept,
    input  logic   sweep_en,
    input  logic   sweep_clr,
    output pixel_t pixel,
    output logic   frame_full,
    output logic   sweep_last,
    output addr_t  sweep_addr
);

    localparam int SAMPLE_W = (`HB_SAMPLES > 1) ? $clog2(`HB_SAMPLES) : 1;
    localparam int ACQ_W = (`HB_ACQS > 1) ? $clog2(`HB_ACQS) : 1;

    logic [SAMPLE_W-1:0] sample_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic last_sample;
    logic last_pixel;
    logic last_acq;

    assign last_sample = (sample_cnt == SAMPLE_W'(`HB_SAMPLES - 1));
    assign last_pixel = &pixel; // pixel count is a power of two
    assign last_acq = (acq_cnt == ACQ_W'(`HB_ACQS - 1));

    assign frame_full = sample_accept & last_sample & last_pixel & last_acq;

    // sample -> pixel -> acquisition
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sample_cnt <= '0;
            pixel <= '0;
            acq_cnt <= '0;
        end else if (sample_accept) begin
            if (last_sample) begin
                sample_cnt <= '0;
                pixel <= pixel + 1'b1; // wraps to 0
                if (last_pixel) begin
                    if (last_acq) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    // address sweep for clear and readout
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sweep_addr <= '0;
        end else if (sweep_clr) begin
            sweep_addr <= '0;
        end else if (sweep_en) begin
            sweep_addr <= sweep_addr + 1'b1;
        end
    end

    assign sweep_last = sweep_en & (&sweep_addr);

endmodule

`default_nettype wire

// File: src/hist_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module hist_ctrl_fsm
    import hist_pkg::*;
(
    input  logic clk,
    input  logic res,
    input  logic frame_full, // last sample of the frame accepted
    input  logic sweep_last,
    output logic busy,
    output logic sweep_en,
    output logic sweep_clr,
    output logic clear_en,
    output logic read_en,
    output logic frame_done
);

    hist_state_t state;
    hist_state_t state_nxt;
    logic drain_cnt; // two cycles in DRAIN

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= CLEAR;
            drain_cnt <= 1'b0;
            busy <= 1'b1;
            frame_done <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == DRAIN) begin
                drain_cnt <= ~drain_cnt;
            end else begin
                drain_cnt <= 1'b0;
            end
            busy <= (state_nxt != ACCUM);
            // one cycle behind the last bin_valid
            frame_done <= (state == DONE);
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            CLEAR: begin
                if (sweep_last) begin
                    state_nxt = ACCUM;
                end
            end
            ACCUM: begin
                if (frame_full) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                // let the last increment retire
                if (drain_cnt) begin
                    state_nxt = READOUT;
                end
            end
            READOUT: begin
                if (sweep_last) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = CLEAR;
            end
            default: begin
                state_nxt = CLEAR;
            end
        endcase
    end

    assign clear_en = (state == CLEAR);
    assign read_en = (state == READOUT);
    assign sweep_en = clear_en | read_en;

    // restart the address sweep on the way into a sweeping state
    assign sweep_clr = (state_nxt != state) &&
                       ((state_nxt == CLEAR) || (state_nxt == READOUT));

endmodule

`default_nettype wire

// File: src/hist_pkg.sv
`default_nettype none

`include "hist_macros.svh"

package hist_pkg;

    typedef logic [`HB_BIN_W-1:0] bin_t;
    typedef logic [`HB_PIXEL_W-1:0] pixel_t;
    typedef logic [`HB_COUNT_W-1:0] count_t;
    typedef logic [`HB_ADDR_W-1:0] addr_t; // pixel in the upper bits

    // one word of the readout stream
    typedef struct packed {
        logic [`HB_WORD_W-`HB_ADDR_W-`HB_COUNT_W-1:0] rsvd; // always zero
        pixel_t pixel;
        bin_t bin;
        count_t count;
    } bin_word_t;

    // accepted sample in flight through the increment pipeline
    typedef struct packed {
        logic valid;
        pixel_t pixel;
        bin_t bin;
    } sample_t;

    typedef enum logic [2:0] {
        CLEAR,
        ACCUM,
        DRAIN,
        READOUT,
        DONE
    } hist_state_t;

endpackage

`default_nettype wire

// File: tests/tb_hist_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module tb_hist_builder
    import hist_pkg::*;
();

    localparam int PIXELS = 1 << `HB_PIXEL_W;
    localparam int BINS = 1 << `HB_BIN_W;
    localparam int WORDS = 1 << `HB_ADDR_W;
    localparam int MAX_COUNT = (1 << `HB_COUNT_W) - 1;
    localparam int FRAME_SAMPLES = `HB_SAMPLES * PIXELS * `HB_ACQS;
    localparam int FRAMES = 3;
    // gapped frame at most 64 + 3 x 640 + 67 cycles and dense frames 64 + 640 + 67 each
    localparam int TIMEOUT_CYCLES = 4000;

    logic      clk;
    logic      res;
    logic      sample_valid;
    bin_t      sample_bin;
    logic      busy;
    logic      bin_valid;
    logic      frame_done;
    bin_word_t bin_word;

    integer seed;
    int     cycle_cnt = 0;
    int     hits [WORDS];   // raw hits per address before saturation
    int     frame_accepts = 0;
    int     frames_seen = 0;
    int     rd_idx = 0;      // next readout word expected
    int     words_checked = 0;
    int     dropped_cnt = 0;
    int     clear_left = WORDS; // clear cycles still to come
    logic   done_due = 1'b0;
    logic   exp_done;
    logic   exp_busy;
    addr_t  acc_addr;

    hist_builder_top u_hist_builder_top (
        .clk          (clk),
        .res          (res),
        .sample_valid (sample_valid),
        .sample_bin   (sample_bin),
        .busy         (busy),
        .bin_valid    (bin_valid),
        .frame_done   (frame_done),
        .bin_word     (bin_word)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input bin_word_t exp, input bin_word_t act);
        if (act !== exp) begin
            abort_run($sformatf(
                "Error at %0d ns: bin_word expected %h (p%0d b%0d c%0d) actual %h (p%0d b%0d c%0d)",
                $time, exp, exp.pixel, exp.bin, exp.count,
                act, act.pixel, act.bin, act.count));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Error at %0d ns: %s expected %b actual %b",
                                $time, name, exp, act));
        end
    endtask

    // pixel of the n-th accepted sample of a frame
    function automatic pixel_t ref_pixel(input int n);
        return pixel_t'((n / `HB_SAMPLES) % PIXELS);
    endfunction

    // expected readout word at position idx of the stream
    function automatic bin_word_t expected_word(input int idx);
        bin_word_t w;
        int n;
        w = '0;
        w.pixel = pixel_t'(idx / BINS); // pixel-major order
        w.bin = bin_t'(idx % BINS);
        n = hits[idx];
        w.count = (n > MAX_COUNT) ? count_t'(MAX_COUNT) : count_t'(n);
        return w;
    endfunction

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: only %0d of %0d frames finished in %0d cycles",
                                frames_seen, FRAMES, TIMEOUT_CYCLES));
        end
    end

    // compare at the falling edge where inputs and outputs are stable
    always @(negedge clk) begin
        if (res) begin
            exp_done = done_due;
            done_due = 1'b0;
            check_flag("frame_done", exp_done, frame_done);
            if (rd_idx > 0 && rd_idx < WORDS) begin
                check_flag("bin_valid", 1'b1, bin_valid); // no hole in the stream
            end
            if (exp_done) begin
                check_flag("bin_valid", 1'b0, bin_valid);
                clear_left = WORDS;
            end
            if (clear_left > 0) begin
                exp_busy = 1'b1; // clear sweep still running
                clear_left = clear_left - 1;
            end else begin
                exp_busy = (frame_accepts == FRAME_SAMPLES);
            end
            check_flag("busy", exp_busy, busy);
            if (bin_valid) begin
                if (rd_idx == 0 && frame_accepts != FRAME_SAMPLES) begin
                    abort_run($sformatf("readout started after %0d accepted samples, not %0d",
                                        frame_accepts, FRAME_SAMPLES));
                end
                check_word(expected_word(rd_idx), bin_word);
                rd_idx = rd_idx + 1;
                words_checked = words_checked + 1;
                if (rd_idx == WORDS) begin
                    done_due = 1'b1;
                end
            end
            if (frame_done) begin
                // next frame starts from cleared bins
                for (int i = 0; i < WORDS; i++) begin
                    hits[i] = 0;
                end
                frame_accepts = 0;
                rd_idx = 0;
                frames_seen = frames_seen + 1;
            end
            if (sample_valid && !busy) begin
                if (frame_accepts == FRAME_SAMPLES) begin
                    abort_run("a sample was accepted after the frame was already full");
                end
                acc_addr = {ref_pixel(frame_accepts), sample_bin};
                hits[acc_addr] = hits[acc_addr] + 1;
                frame_accepts = frame_accepts + 1;
            end else if (sample_valid) begin
                dropped_cnt = dropped_cnt + 1; // strobe while busy
            end
        end
    end

    // random bins with 0 to 2 idle cycles after each strobe
    task automatic send_gapped_frame();
        int start;
        int gap;
        start = frames_seen;
        while (frames_seen == start) begin
            @(posedge clk);
            sample_valid <= 1'b1;
            sample_bin <= bin_t'($random(seed));
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                sample_valid <= 1'b0;
            end
        end
    endtask

    // one bin every cycle to hit forwarding and saturation
    task automatic send_same_bin_frame(input bin_t bin);
        int start;
        start = frames_seen;
        while (frames_seen == start) begin
            @(posedge clk);
            sample_valid <= 1'b1;
            sample_bin <= bin;
        end
    endtask

    // random bins every cycle that keep coming through clear, drain and readout
    task automatic send_stream_frame();
        int start;
        start = frames_seen;
        while (frames_seen == start) begin
            @(posedge clk);
            sample_valid <= 1'b1;
            sample_bin <= bin_t'($random(seed));
        end
    endtask

    initial begin
        res = 1'b0;
        sample_valid = 1'b0;
        sample_bin = '0;
        seed = 15;
        for (int i = 0; i < WORDS; i++) begin
            hits[i] = 0;
        end
        repeat (16) @(posedge clk);
        res <= 1'b1;

        send_gapped_frame();
        send_same_bin_frame(bin_t'(9));
        send_stream_frame();

        @(posedge clk);
        sample_valid <= 1'b0;
        repeat (4) @(posedge clk);

        if (frames_seen == FRAMES && words_checked == FRAMES * WORDS && dropped_cnt > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run($sformatf("run ended with %0d frames, %0d words, %0d dropped strobes",
                                frames_seen, words_checked, dropped_cnt));
        end
    end

endmodule

`default_nettype wire
